// ==== src/ahb_pkg.sv ====
// AHB-Lite bus widths, transfer type and size codes, response value and beat struct
`default_nettype none

package ahb_pkg;

  // Bus widths
  localparam int HADDR_BITS    = 32;
  localparam int HDATA_BITS    = 32;
  localparam int HDATA_BYTES   = HDATA_BITS / 8;
  localparam int BYTE_IDX_BITS = $clog2(HDATA_BYTES);

  typedef logic [HADDR_BITS -1:0] haddr_t;
  typedef logic [HDATA_BITS -1:0] hdata_t;
  typedef logic [HDATA_BYTES-1:0] hbe_t;
  typedef logic [            2:0] hsize_t;

  // Transfer type
  typedef enum logic [1:0] {HTRANS_IDLE, HTRANS_BUSY, HTRANS_NONSEQ, HTRANS_SEQ} htrans_t;

  // Sizes up to the bus width only
  localparam hsize_t HSIZE_BYTE  = 3'b000;
  localparam hsize_t HSIZE_HWORD = 3'b001;
  localparam hsize_t HSIZE_WORD  = 3'b010;

  // Slave never signals an error
  localparam logic HRESP_OKAY = 1'b0;

  // Data-phase view of an accepted address phase
  typedef struct packed {
    logic   valid;
    logic   write;
    hsize_t size;
    haddr_t addr;
    hbe_t   be;
  } ahb_beat_t;

endpackage

`default_nettype wire

// ==== src/mem_pkg.sv ====
// Line geometry, tag and timer widths, flush timeout and memory request/response structs
`default_nettype none

package mem_pkg;

  //////////////////////////////////////////////////
  // Line geometry, derived from the AHB word

  localparam int LINE_WORDS       = 4;
  localparam int LINE_BYTES       = LINE_WORDS * ahb_pkg::HDATA_BYTES;
  localparam int LINE_BITS        = LINE_BYTES * 8;
  localparam int LINE_OFFSET_BITS = $clog2(LINE_BYTES);
  localparam int WORD_IDX_BITS    = $clog2(LINE_WORDS);
  localparam int TAG_BITS         = ahb_pkg::HADDR_BITS - LINE_OFFSET_BITS;

  // Idle cycles before a dirty line goes out on its own
  localparam int TIMEOUT_CYCLES   = 16;
  localparam int TIMER_BITS       = $clog2(TIMEOUT_CYCLES) + 1;

  typedef logic [LINE_BITS    -1:0] line_t;
  typedef logic [LINE_BYTES   -1:0] line_be_t;
  typedef logic [TAG_BITS     -1:0] tag_t;
  typedef logic [WORD_IDX_BITS-1:0] word_idx_t;
  typedef logic [TIMER_BITS   -1:0] timer_t;

  //////////////////////////////////////////////////
  // Memory port, one whole line per request

  // Held stable from valid until accepted
  typedef struct packed {
    logic     valid;
    logic     write;
    tag_t     tag;
    line_be_t be;
    line_t    data;
  } mem_req_t;

  // Read data, one pulse per read request
  typedef struct packed {
    logic  rvalid;
    line_t data;
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== src/ahb_front.sv ====
// AHB address-phase decode, byte-enable generation, beat register and combined ready
`default_nettype none

module ahb_front
(
  input  logic               HCLK,
  input  logic               HRESETn,

  // AHB address phase
  input  logic               hsel_i,
  input  ahb_pkg::htrans_t   htrans_i,
  input  ahb_pkg::hsize_t    hsize_i,
  input  logic               hwrite_i,
  input  ahb_pkg::haddr_t    haddr_i,
  input  logic               hready_i,

  // To the peers
  output ahb_pkg::ahb_beat_t beat_o,
  output mem_pkg::tag_t      addr_tag_o,
  output logic               addr_rd_o,
  output logic               addr_wr_o,

  // AHB response
  output logic               hreadyout_o,
  output logic               hresp_o,
  input  logic               wr_ready_i,
  input  logic               rd_ready_i
);

  logic xfer;

  // Lanes touched by a transfer, size never wider than the bus
  function automatic ahb_pkg::hbe_t gen_be(input ahb_pkg::hsize_t size,
                                           input logic [ahb_pkg::BYTE_IDX_BITS-1:0] offs);
    case (size)
      ahb_pkg::HSIZE_BYTE:  gen_be = ahb_pkg::hbe_t'(1) << offs;
      ahb_pkg::HSIZE_HWORD: gen_be = ahb_pkg::hbe_t'(3) << {offs[ahb_pkg::BYTE_IDX_BITS-1:1], 1'b0};
      default:              gen_be = '1;
    endcase
  endfunction

  // Real transfer, BUSY and IDLE ignored
  assign xfer = hsel_i & ((htrans_i == ahb_pkg::HTRANS_NONSEQ) |
                          (htrans_i == ahb_pkg::HTRANS_SEQ));

  // Address phase only counts when HREADY is high
  assign addr_rd_o  = hready_i & xfer & ~hwrite_i;
  assign addr_wr_o  = hready_i & xfer &  hwrite_i;
  assign addr_tag_o = haddr_i[ahb_pkg::HADDR_BITS-1:mem_pkg::LINE_OFFSET_BITS];

  // Beat register, holds while the data phase is stretched
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      beat_o <= '0;
    else if (hready_i)
    begin
      beat_o.valid <= xfer;
      beat_o.write <= hwrite_i;
      beat_o.size  <= hsize_i;
      beat_o.addr  <= haddr_i;
      beat_o.be    <= gen_be(hsize_i, haddr_i[ahb_pkg::BYTE_IDX_BITS-1:0]);
    end
  end

  // Both peers must agree before the data phase ends
  assign hreadyout_o = wr_ready_i & rd_ready_i;
  assign hresp_o     = ahb_pkg::HRESP_OKAY;

endmodule

`default_nettype wire

// ==== src/write_buffer.sv ====
// Merging line buffer with tag, dirty and byte enables, flush FSM, timeout timer and hold register
`default_nettype none

module write_buffer
(
  input  logic               HCLK,
  input  logic               HRESETn,
  input  ahb_pkg::ahb_beat_t beat_i,
  input  ahb_pkg::hdata_t    hwdata_i,
  input  mem_pkg::tag_t      addr_tag_i,
  input  logic               addr_rd_i,
  input  logic               addr_wr_i,
  input  logic               grant_i,
  input  logic               mem_ready_i,
  output mem_pkg::mem_req_t  req_o,
  output logic               wr_ready_o
);

  typedef enum logic {WB_IDLE, WB_WAIT} wb_state_t;

  wb_state_t          state_q, state_d;

  // Line being filled
  mem_pkg::line_t     line_q, line_d;
  mem_pkg::line_be_t  be_q, be_d;
  mem_pkg::tag_t      tag_q, tag_d;
  logic               dirty_q, dirty_d;

  // Outgoing line, waits here for the memory
  logic               hold_vld_q;
  mem_pkg::tag_t      hold_tag_q;
  mem_pkg::line_be_t  hold_be_q;
  mem_pkg::line_t     hold_line_q;

  mem_pkg::timer_t    timer_q;
  mem_pkg::word_idx_t word_idx;
  mem_pkg::line_be_t  wr_be;
  logic               merge, rd_beat, hold_free;
  logic               access_flush, tmo_flush, flush;

  //////////////////////////////////////////////////
  // Merge in the data phase

  assign rd_beat  = beat_i.valid & ~beat_i.write;
  assign merge    = beat_i.valid &  beat_i.write & wr_ready_o;
  assign word_idx = beat_i.addr[mem_pkg::LINE_OFFSET_BITS-1:ahb_pkg::BYTE_IDX_BITS];
  assign wr_be    = merge ? mem_pkg::line_be_t'(beat_i.be) << (word_idx * ahb_pkg::HDATA_BYTES)
                          : '0;

  always_comb
  begin
    line_d = line_q;
    for (int b = 0; b < mem_pkg::LINE_BYTES; b++)
    begin
      if (wr_be[b])
        line_d[b*8 +: 8] = hwdata_i[(b % ahb_pkg::HDATA_BYTES)*8 +: 8];
    end
  end

  // Line state including this cycle's merge
  assign be_d    = be_q | wr_be;
  assign dirty_d = dirty_q | merge;
  assign tag_d   = merge ? beat_i.addr[ahb_pkg::HADDR_BITS-1:mem_pkg::LINE_OFFSET_BITS] : tag_q;

  //////////////////////////////////////////////////
  // Flush decision, made in the address phase

  // Write to another line, or read of the dirty one
  assign access_flush = dirty_d & ((addr_wr_i & (addr_tag_i != tag_d)) |
                                   (addr_rd_i & (addr_tag_i == tag_d)));
  // Timer only counts while dirty; held back during a read
  assign tmo_flush = (timer_q == mem_pkg::timer_t'(mem_pkg::TIMEOUT_CYCLES)) & ~merge & ~rd_beat;
  assign hold_free = ~hold_vld_q | (grant_i & mem_ready_i);

  always_comb
  begin
    state_d = state_q;
    flush   = 1'b0;
    case (state_q)
      WB_IDLE:
        if (access_flush | tmo_flush)
        begin
          if (hold_free)
            flush = 1'b1;
          else if (access_flush)
            state_d = WB_WAIT;
        end
      WB_WAIT:
        if (hold_free)
        begin
          flush   = 1'b1;
          state_d = WB_IDLE;
        end
    endcase
  end

  // Data phase stalls while a flush waits
  assign wr_ready_o = (state_q == WB_IDLE);

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state_q    <= WB_IDLE;
      dirty_q    <= 1'b0;
      be_q       <= '0;
      hold_vld_q <= 1'b0;
      timer_q    <= '0;
    end
    else
    begin
      state_q <= state_d;
      dirty_q <= dirty_d & ~flush;
      be_q    <= flush ? '0 : be_d;
      if (flush)
        hold_vld_q <= 1'b1;
      else if (grant_i & mem_ready_i)
        hold_vld_q <= 1'b0;
      // Restart on every write beat, saturate at the limit
      if (flush | merge | ~dirty_d)
        timer_q <= '0;
      else if (timer_q != mem_pkg::timer_t'(mem_pkg::TIMEOUT_CYCLES))
        timer_q <= timer_q + 1'b1;
    end
  end

  always_ff @(posedge HCLK)
  begin
    line_q <= line_d;
    tag_q  <= tag_d;
    if (flush)
    begin
      hold_tag_q  <= tag_d;
      hold_be_q   <= be_d;
      hold_line_q <= line_d;
    end
  end

  assign req_o = '{valid: hold_vld_q, write: 1'b1, tag: hold_tag_q,
                   be: hold_be_q, data: hold_line_q};

endmodule

`default_nettype wire

// ==== src/read_unit.sv ====
// Line read requester, response wait FSM and HRDATA word select
`default_nettype none

module read_unit
(
  input  logic               HCLK,
  input  logic               HRESETn,
  input  ahb_pkg::ahb_beat_t beat_i,
  input  logic               grant_i,
  input  logic               mem_ready_i,
  input  mem_pkg::mem_rsp_t  rsp_i,
  output mem_pkg::mem_req_t  req_o,
  output logic               rd_ready_o,
  output ahb_pkg::hdata_t    hrdata_o
);

  typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_WAIT} rd_state_t;

  rd_state_t          state_q, state_d;
  logic               rd_beat, done_q, req_vld, accepted;
  mem_pkg::word_idx_t word_idx;

  assign rd_beat  = beat_i.valid & ~beat_i.write;
  assign word_idx = beat_i.addr[mem_pkg::LINE_OFFSET_BITS-1:ahb_pkg::BYTE_IDX_BITS];

  // Raised in the beat cycle, fields come from the stalled beat
  assign req_vld  = rd_beat & ~done_q & (state_q != RD_WAIT);
  assign accepted = req_vld & grant_i & mem_ready_i;
  assign req_o    = '{valid: req_vld, write: 1'b0,
                      tag: beat_i.addr[ahb_pkg::HADDR_BITS-1:mem_pkg::LINE_OFFSET_BITS],
                      be: '1, data: '0};

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      RD_IDLE:
        if (accepted)
          state_d = RD_WAIT;
        else if (req_vld)
          state_d = RD_REQ;
      RD_REQ:
        if (accepted)
          state_d = RD_WAIT;
      RD_WAIT:
        if (rsp_i.rvalid)
          state_d = RD_IDLE;
      default:
        state_d = RD_IDLE;
    endcase
  end

  // Data phase ends the cycle after the response
  assign rd_ready_o = ~rd_beat | done_q;

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state_q <= RD_IDLE;
      done_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      done_q  <= (state_q == RD_WAIT) & rsp_i.rvalid;
    end
  end

  // Addressed word of the returned line
  always_ff @(posedge HCLK)
  begin
    if ((state_q == RD_WAIT) && rsp_i.rvalid)
      hrdata_o <= rsp_i.data[word_idx*ahb_pkg::HDATA_BITS +: ahb_pkg::HDATA_BITS];
  end

endmodule

`default_nettype wire

// ==== src/mem_arbiter.sv ====
// Fixed-priority memory port arbiter, write unit ahead of read unit
`default_nettype none

module mem_arbiter
(
  // Peer requests
  input  mem_pkg::mem_req_t wr_req_i,
  input  mem_pkg::mem_req_t rd_req_i,
  input  logic              mem_ready_i,

  // Acceptance strobes back to the peers
  output logic              wr_grant_o,
  output logic              rd_grant_o,

  // Shared line-wide memory port
  output mem_pkg::mem_req_t mem_req_o
);

  logic wr_sel;
  logic rd_sel;

  //////////////////////////////////////////////////
  // Selection
  //
  // A write flush is raised no later than the read
  // that could hit it, so a read never sits on the
  // port when a write turns up. Write-first is
  // therefore enough to keep the choice stable
  // until the memory takes the request

  assign wr_sel = wr_req_i.valid;
  assign rd_sel = rd_req_i.valid & ~wr_req_i.valid;

  // Pending write beats everything
  assign mem_req_o = wr_sel ? wr_req_i : rd_req_i;

  //////////////////////////////////////////////////
  // Grants

  // Only in the cycle the memory accepts
  assign wr_grant_o = wr_sel & mem_ready_i;
  assign rd_grant_o = rd_sel & mem_ready_i;

endmodule

`default_nettype wire

// ==== src/sdram_ahb_top.sv ====
// AHB-Lite slave front end of the SDRAM controller, front end, write buffer, read unit, arbiter
`default_nettype none

module sdram_ahb_top
(
  input  logic              HCLK,
  input  logic              HRESETn,

  // AHB-Lite slave
  input  logic              HSEL,
  input  ahb_pkg::htrans_t  HTRANS,
  input  ahb_pkg::hsize_t   HSIZE,
  input  logic              HWRITE,
  input  ahb_pkg::haddr_t   HADDR,
  input  ahb_pkg::hdata_t   HWDATA,
  input  logic              HREADY,
  output ahb_pkg::hdata_t   HRDATA,
  output logic              HREADYOUT,
  output logic              HRESP,

  // Line-wide memory port
  output mem_pkg::mem_req_t mem_req_o,
  input  logic              mem_ready_i,
  input  mem_pkg::mem_rsp_t mem_rsp_i
);

  ahb_pkg::ahb_beat_t beat;
  mem_pkg::tag_t      addr_tag;
  logic               addr_rd, addr_wr;
  logic               wr_ready, rd_ready;
  logic               wr_grant, rd_grant;
  mem_pkg::mem_req_t  wr_req, rd_req;

  ahb_front u_front (
    .HCLK, .HRESETn,
    .hsel_i (HSEL), .htrans_i (HTRANS), .hsize_i (HSIZE), .hwrite_i (HWRITE),
    .haddr_i (HADDR), .hready_i (HREADY),
    .beat_o (beat), .addr_tag_o (addr_tag), .addr_rd_o (addr_rd), .addr_wr_o (addr_wr),
    .hreadyout_o (HREADYOUT), .hresp_o (HRESP),
    .wr_ready_i (wr_ready), .rd_ready_i (rd_ready));

  write_buffer u_wbuf (
    .HCLK, .HRESETn,
    .beat_i (beat), .hwdata_i (HWDATA), .addr_tag_i (addr_tag),
    .addr_rd_i (addr_rd), .addr_wr_i (addr_wr),
    .grant_i (wr_grant), .mem_ready_i, .req_o (wr_req), .wr_ready_o (wr_ready));

  read_unit u_rd (
    .HCLK, .HRESETn,
    .beat_i (beat), .grant_i (rd_grant), .mem_ready_i, .rsp_i (mem_rsp_i),
    .req_o (rd_req), .rd_ready_o (rd_ready), .hrdata_o (HRDATA));

  mem_arbiter u_arb (
    .wr_req_i (wr_req), .rd_req_i (rd_req), .mem_ready_i,
    .wr_grant_o (wr_grant), .rd_grant_o (rd_grant), .mem_req_o);

endmodule

`default_nettype wire

// ==== testbench/tb_sdram_ahb_chk.sv ====
// Bound concurrent assertions on the memory request handshake and the AHB response
`default_nettype none

module tb_sdram_ahb_chk
(
  input logic              HCLK,
  input logic              HRESETn,
  input logic              HRESP,
  input logic              mem_ready_i,
  input mem_pkg::mem_req_t mem_req_o
);

  // Request frozen until the memory takes it
  a_req_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (mem_req_o.valid && !mem_ready_i) |=> $stable(mem_req_o))
    else $error("memory request changed while waiting for ready");

  // Slave never answers with an error
  a_hresp_okay: assert property (@(posedge HCLK) disable iff (!HRESETn)
    HRESP == ahb_pkg::HRESP_OKAY)
    else $error("HRESP left the OKAY value");

endmodule

bind sdram_ahb_top tb_sdram_ahb_chk u_chk (
  .HCLK        (HCLK),
  .HRESETn     (HRESETn),
  .HRESP       (HRESP),
  .mem_ready_i (mem_ready_i),
  .mem_req_o   (mem_req_o)
);

`default_nettype wire

// ==== testbench/tb_top.sv ====
// Testbench top with clock, reset, AHB driver, memory responder, byte model and checks
`default_nettype none

module tb_top;

  localparam int MEM_LINES = 64;
  localparam int MEM_BYTES = MEM_LINES * mem_pkg::LINE_BYTES;
  localparam int WAIT_MAX  = 2000;

  logic               HCLK;
  logic               HRESETn;
  logic               HSEL;
  logic               HWRITE;
  ahb_pkg::htrans_t   HTRANS;
  ahb_pkg::hsize_t    HSIZE;
  ahb_pkg::haddr_t    HADDR;
  ahb_pkg::hdata_t    HWDATA;
  ahb_pkg::hdata_t    HRDATA;
  logic               HREADYOUT;
  logic               HRESP;
  mem_pkg::mem_req_t  mem_req_o;
  logic               mem_ready_i;
  mem_pkg::mem_rsp_t  mem_rsp_i;

  integer             seed;
  int                 n_checks;
  int                 n_errors;
  int                 stall_mode;

  // Memory contents and the reference model, one byte per address
  logic [7:0]         mem_b [0:MEM_BYTES-1];
  logic [7:0]         model [0:MEM_BYTES-1];

  // Accepted memory requests, in order
  bit                 log_wr [$];
  mem_pkg::tag_t      log_tag [$];
  mem_pkg::line_be_t  log_be [$];

  logic               rd_pend;
  int                 rd_cnt;
  mem_pkg::line_t     rd_line;

  // Single slave, so HREADY is its own HREADYOUT
  sdram_ahb_top u_dut (
    .HCLK, .HRESETn, .HSEL, .HTRANS, .HSIZE, .HWRITE, .HADDR, .HWDATA,
    .HREADY (HREADYOUT), .HRDATA, .HREADYOUT, .HRESP,
    .mem_req_o, .mem_ready_i, .mem_rsp_i);

  initial
  begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  // Fill pattern over the whole address
  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a ^ (a >> 3) ^ 8'h5a);
  endfunction

  // AHB lane rule from size and low address bits
  function automatic ahb_pkg::hbe_t be_of(input ahb_pkg::hsize_t sz, input ahb_pkg::haddr_t a);
    case (sz)
      ahb_pkg::HSIZE_BYTE:  return ahb_pkg::hbe_t'(4'b0001 << a[1:0]);
      ahb_pkg::HSIZE_HWORD: return a[1] ? 4'b1100 : 4'b0011;
      default:              return 4'b1111;
    endcase
  endfunction

  function automatic int first_of(input bit wr, input mem_pkg::tag_t tag);
    for (int i = 0; i < log_wr.size(); i++)
    begin
      if (log_wr[i] == wr && log_tag[i] == tag)
        return i;
    end
    return -1;
  endfunction

  //////////////////////////////////////////////////
  // Memory responder

  always @(posedge HCLK)
  begin : responder
    int idx;
    mem_rsp_i.rvalid <= 1'b0;
    if (rd_pend)
    begin
      if (rd_cnt == 1)
      begin
        mem_rsp_i.rvalid <= 1'b1;
        mem_rsp_i.data   <= rd_line;
        rd_pend = 1'b0;
      end
      else
        rd_cnt--;
    end
    if (HRESETn && mem_req_o.valid && mem_ready_i)
    begin
      idx = int'(mem_req_o.tag[5:0]) * mem_pkg::LINE_BYTES;
      if (mem_req_o.tag >= mem_pkg::tag_t'(MEM_LINES))
      begin
        $display("Memory request tag %h lies outside the memory", mem_req_o.tag);
        n_errors++;
      end
      log_wr.push_back(mem_req_o.write);
      log_tag.push_back(mem_req_o.tag);
      log_be.push_back(mem_req_o.be);
      if (mem_req_o.write)
      begin
        for (int b = 0; b < mem_pkg::LINE_BYTES; b++)
        begin
          if (mem_req_o.be[b])
            mem_b[idx + b] = mem_req_o.data[b*8 +: 8];
        end
      end
      else
      begin
        if (rd_pend)
        begin
          $display("A second memory read was issued while one was outstanding");
          n_errors++;
        end
        // Line captured at acceptance, answered 1 to 4 cycles later
        for (int b = 0; b < mem_pkg::LINE_BYTES; b++)
          rd_line[b*8 +: 8] = mem_b[idx + b];
        rd_pend = 1'b1;
        rd_cnt  = 1 + ($random(seed) & 3);
      end
    end
    // Ready pattern for the next cycle
    case (stall_mode)
      0:       mem_ready_i <= 1'b1;
      1:       mem_ready_i <= (($random(seed) & 3) != 0);
      default: if (($random(seed) & 15) == 0) mem_ready_i <= ~mem_ready_i;
    endcase
  end

  //////////////////////////////////////////////////
  // AHB driver

  task automatic wait_ready();
    int t;
    t = 0;
    @(negedge HCLK);
    while (!HREADYOUT && t < WAIT_MAX)
    begin
      @(negedge HCLK);
      t++;
    end
    if (!HREADYOUT)
    begin
      $display("HREADYOUT stayed low for %0d cycles at address %h", WAIT_MAX, HADDR);
      n_errors++;
    end
  endtask

  // Address phase, then data phase; returns on the last data-phase cycle
  task automatic xfer(input logic wr, input ahb_pkg::hsize_t sz, input ahb_pkg::haddr_t a,
                      input ahb_pkg::hdata_t wd, output ahb_pkg::hdata_t rd);
    @(posedge HCLK);
    HSEL   <= 1'b1;
    HTRANS <= ahb_pkg::HTRANS_NONSEQ;
    HSIZE  <= sz;
    HWRITE <= wr;
    HADDR  <= a;
    wait_ready();
    @(posedge HCLK);
    HSEL   <= 1'b0;
    HTRANS <= ahb_pkg::HTRANS_IDLE;
    if (wr)
      HWDATA <= wd;
    wait_ready();
    rd = HRDATA;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge HCLK);
  endtask

  task automatic rand_addr(input int line, output ahb_pkg::haddr_t a, output ahb_pkg::hsize_t sz);
    sz = ahb_pkg::hsize_t'($unsigned($random(seed)) % 3);
    a  = ahb_pkg::haddr_t'(line * mem_pkg::LINE_BYTES + ($random(seed) & 15));
    if (sz == ahb_pkg::HSIZE_HWORD)
      a[0] = 1'b0;
    if (sz == ahb_pkg::HSIZE_WORD)
      a[1:0] = 2'b00;
  endtask

  task automatic do_write(input ahb_pkg::haddr_t a, input ahb_pkg::hsize_t sz);
    ahb_pkg::hdata_t wd;
    ahb_pkg::hdata_t rd;
    ahb_pkg::hbe_t   be;
    wd = $random(seed);
    be = be_of(sz, a);
    xfer(1'b1, sz, a, wd, rd);
    for (int k = 0; k < 4; k++)
    begin
      if (be[k])
        model[int'({a[31:2], 2'b00}) + k] = wd[k*8 +: 8];
    end
  endtask

  // Only the lanes of the transfer size are compared
  task automatic do_read(input ahb_pkg::haddr_t a, input ahb_pkg::hsize_t sz);
    ahb_pkg::hdata_t rd;
    ahb_pkg::hdata_t exp;
    ahb_pkg::hdata_t mask;
    ahb_pkg::hbe_t   be;
    xfer(1'b0, sz, a, '0, rd);
    be = be_of(sz, a);
    for (int k = 0; k < 4; k++)
    begin
      mask[k*8 +: 8] = be[k] ? 8'hff : 8'h00;
      exp[k*8 +: 8]  = be[k] ? model[int'({a[31:2], 2'b00}) + k] : 8'h00;
    end
    n_checks++;
    if ((rd & mask) != exp)
    begin
      $display("FAIL HRDATA addr %h: got %h expected %h", a, rd & mask, exp);
      n_errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Behaviors

  // Let the buffer time out and the port drain
  task automatic settle();
    int saved;
    int t;
    saved      = stall_mode;
    stall_mode = 0;
    idle(mem_pkg::TIMEOUT_CYCLES + 6);
    t = 0;
    @(negedge HCLK);
    while (mem_req_o.valid && t < WAIT_MAX)
    begin
      @(negedge HCLK);
      t++;
    end
    if (mem_req_o.valid)
    begin
      $display("Memory port did not drain while the bus was idle");
      n_errors++;
    end
    idle(4);
    stall_mode = saved;
    log_wr.delete();
    log_tag.delete();
    log_be.delete();
  endtask

  // Coherence over four lines
  task automatic run_random(input int n);
    ahb_pkg::haddr_t a;
    ahb_pkg::hsize_t sz;
    repeat (n)
    begin
      rand_addr(4 + ($random(seed) & 3), a, sz);
      if ($random(seed) & 1)
        do_write(a, sz);
      else
        do_read(a, sz);
    end
  endtask

  task automatic check_merge(input int l1, input int l2);
    ahb_pkg::haddr_t   a;
    ahb_pkg::hsize_t   sz;
    mem_pkg::line_be_t uni;
    int                t;
    int                hits;
    int                last;
    settle();
    uni = '0;
    repeat (4)
    begin
      rand_addr(l1, a, sz);
      do_write(a, sz);
      uni |= mem_pkg::line_be_t'(be_of(sz, a)) << (int'(a[3:2]) * 4);
    end
    // Miss pushes the first line out
    rand_addr(l2, a, sz);
    do_write(a, sz);
    t = 0;
    while (first_of(1'b1, mem_pkg::tag_t'(l1)) < 0 && t < WAIT_MAX)
    begin
      @(negedge HCLK);
      t++;
    end
    idle(40);
    hits = 0;
    last = -1;
    for (int i = 0; i < log_wr.size(); i++)
    begin
      if (log_wr[i] && log_tag[i] == mem_pkg::tag_t'(l1))
      begin
        hits++;
        last = i;
      end
    end
    n_checks++;
    if (hits != 1)
    begin
      $display("Merged line %0d was written to memory %0d times instead of once", l1, hits);
      n_errors++;
    end
    else if (log_be[last] != uni)
    begin
      $display("FAIL mem_req_o.be: got %h expected %h", log_be[last], uni);
      n_errors++;
    end
  endtask

  task automatic check_wbr(input int l);
    ahb_pkg::haddr_t a;
    ahb_pkg::hsize_t sz;
    int              iw;
    int              ir;
    settle();
    rand_addr(l, a, sz);
    do_write(a, sz);
    do_read(a, sz);
    iw = first_of(1'b1, mem_pkg::tag_t'(l));
    ir = first_of(1'b0, mem_pkg::tag_t'(l));
    n_checks++;
    if (iw < 0 || ir < 0 || iw > ir)
    begin
      $display("Dirty line %0d was not written before it was read (write %0d, read %0d)",
               l, iw, ir);
      n_errors++;
    end
  endtask

  task automatic check_timeout(input int l);
    ahb_pkg::haddr_t a;
    ahb_pkg::hsize_t sz;
    int              t;
    stall_mode = 0;
    settle();
    rand_addr(l, a, sz);
    do_write(a, sz);
    t = 0;
    while (first_of(1'b1, mem_pkg::tag_t'(l)) < 0 && t <= mem_pkg::TIMEOUT_CYCLES + 8)
    begin
      @(negedge HCLK);
      t++;
    end
    n_checks++;
    if (first_of(1'b1, mem_pkg::tag_t'(l)) < 0)
    begin
      $display("Idle dirty line %0d was not flushed within %0d cycles",
               l, mem_pkg::TIMEOUT_CYCLES + 8);
      n_errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Sequence

  initial
  begin
    seed        = 55;
    n_checks    = 0;
    n_errors    = 0;
    stall_mode  = 0;
    rd_pend     = 1'b0;
    rd_cnt      = 0;
    HRESETn     = 1'b0;
    HSEL        = 1'b0;
    HTRANS      = ahb_pkg::HTRANS_IDLE;
    HSIZE       = ahb_pkg::HSIZE_WORD;
    HWRITE      = 1'b0;
    HADDR       = '0;
    HWDATA      = '0;
    mem_ready_i = 1'b1;
    mem_rsp_i   = '0;
    for (int i = 0; i < MEM_BYTES; i++)
    begin
      mem_b[i] = fill_byte(i);
      model[i] = fill_byte(i);
    end
    repeat (3) @(posedge HCLK);
    HRESETn <= 1'b1;
    idle(2);

    // Random ready
    stall_mode = 1;
    run_random(300);
    check_merge(5, 6);
    check_wbr(7);
    check_timeout(4);

    // Long stretches without ready
    stall_mode = 2;
    run_random(200);
    check_merge(4, 7);
    check_wbr(5);
    for (int l = 4; l < 8; l++)
    begin
      for (int w = 0; w < mem_pkg::LINE_WORDS; w++)
        do_read(ahb_pkg::haddr_t'(l * mem_pkg::LINE_BYTES + w * 4), ahb_pkg::HSIZE_WORD);
    end
    idle(4);

    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/ahb_pkg.sv
src/mem_pkg.sv
src/ahb_front.sv
src/write_buffer.sv
src/read_unit.sv
src/mem_arbiter.sv
src/sdram_ahb_top.sv
testbench/tb_sdram_ahb_chk.sv
testbench/tb_top.sv

// ==== Makefile ====
TOP = tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP) \
		--Mdir obj_dir -o V$(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
